//--- verilog/dcache_defs.svh
// data cache geometry
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cpu and memory word
`define DCACHE_ADDR_W   32
`define DCACHE_DATA_W   64
`define DCACHE_STRB_W   8

// address split: tag | index | offset
`define DCACHE_OFFSET_W 3
`define DCACHE_INDEX_W  6
`define DCACHE_SETS     64
`define DCACHE_TAG_W    23

// replacement ages saturate
`define DCACHE_AGE_W    3
`define DCACHE_AGE_MAX  7

`endif

//--- verilog/cache_pkg.sv
// cache internal types
`default_nettype none

`include "dcache_defs.svh"

package cache_pkg;

    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_AGE_W-1:0]   age_t;

    // one bit, two ways
    typedef logic [0:0] way_t;

    // controller FSM
    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_HIT,
        S_WRITEBACK,
        S_REFILL
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- verilog/bus_pkg.sv
// cpu and memory side types
`default_nettype none

`include "dcache_defs.svh"

package bus_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [`DCACHE_DATA_W-1:0] word_t;
    typedef logic [`DCACHE_STRB_W-1:0] strb_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_WRITEBACK,
        MEM_REFILL
    } mem_req_e;

endpackage

`default_nettype wire

//--- verilog/dcache_tag_store.sv
// two-way tag and valid store
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_tag_store import cache_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire index_t      index_i,
    input  wire logic        tag_we_i,
    input  wire way_t        way_i,
    input  wire tag_t        tag_i,
    output tag_t [1:0]       rd_tag_o,
    output logic [1:0]       rd_valid_o
);

    tag_t tag_q   [2][`DCACHE_SETS];
    logic valid_q [2][`DCACHE_SETS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `DCACHE_SETS; s++) begin
                    valid_q[w][s] <= 1'b0;
                end
            end
            rd_valid_o <= '0;
        end else begin
            if (tag_we_i) begin
                valid_q[way_i][index_i] <= 1'b1;
            end
            for (int w = 0; w < 2; w++) begin
                // a written way reads back its new state
                if (tag_we_i && (way_i == way_t'(w))) begin
                    rd_valid_o[w] <= 1'b1;
                end else begin
                    rd_valid_o[w] <= valid_q[w][index_i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_q[way_i][index_i] <= tag_i;
        end
        for (int w = 0; w < 2; w++) begin
            if (tag_we_i && (way_i == way_t'(w))) begin
                rd_tag_o[w] <= tag_i;
            end else begin
                rd_tag_o[w] <= tag_q[w][index_i];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_data_store.sv
// two-way data store
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_data_store import cache_pkg::*, bus_pkg::*; (
    input  wire logic        clk,
    input  wire logic        we_i,
    input  wire index_t      index_i,
    input  wire way_t        way_i,
    input  wire strb_t       strb_i,
    input  wire word_t       wdata_i,
    output word_t [1:0]      rd_word_o
);

    word_t mem_q [2][`DCACHE_SETS];
    word_t merged;

    // strobed bytes from wdata, rest from the stored word
    always_comb begin
        for (int b = 0; b < `DCACHE_STRB_W; b++) begin
            merged[b*8 +: 8] = strb_i[b] ? wdata_i[b*8 +: 8] : mem_q[way_i][index_i][b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[way_i][index_i] <= merged;
        end
        for (int w = 0; w < 2; w++) begin
            if (we_i && (way_i == way_t'(w))) begin
                rd_word_o[w] <= merged;
            end else begin
                rd_word_o[w] <= mem_q[w][index_i];
            end
        end
    end

    // the controller never writes an empty strobe
    assert property (@(posedge clk) we_i |-> (strb_i != '0));

endmodule

`default_nettype wire

//--- verilog/dcache_replace.sv
// dirty bits and age-based victim choice
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_replace import cache_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n_i,
    input  wire index_t      index_i,
    input  wire logic [1:0]  valid_i,
    input  wire logic        hit_i,
    input  wire way_t        hit_way_i,
    input  wire logic        write_hit_i,
    input  wire logic        clean_i,
    output way_t             victim_way_o,
    output logic             victim_dirty_o
);

    age_t age_q   [2][`DCACHE_SETS];
    logic dirty_q [2][`DCACHE_SETS];

    way_t victim;
    way_t other_way;
    age_t other_age;

    // invalid ways first, then the older one, tie to way 0
    always_comb begin
        if (!valid_i[0]) begin
            victim = 1'b0;
        end else if (!valid_i[1]) begin
            victim = 1'b1;
        end else if (age_q[1][index_i] > age_q[0][index_i]) begin
            victim = 1'b1;
        end else begin
            victim = 1'b0;
        end
    end

    assign victim_way_o   = victim;
    assign victim_dirty_o = dirty_q[victim][index_i];

    assign other_way = ~hit_way_i;
    assign other_age = age_q[other_way][index_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `DCACHE_SETS; s++) begin
                    age_q[w][s]   <= '0;
                    dirty_q[w][s] <= 1'b0;
                end
            end
        end else begin
            if (hit_i) begin
                age_q[hit_way_i][index_i] <= '0;
                if (other_age != age_t'(`DCACHE_AGE_MAX)) begin
                    age_q[other_way][index_i] <= age_t'(other_age + 1'b1);
                end
            end
            if (write_hit_i) begin
                dirty_q[hit_way_i][index_i] <= 1'b1;
            end
            if (clean_i) begin
                dirty_q[victim][index_i] <= 1'b0;
            end
        end
    end

    // only a dirty victim gets written back
    assert property (@(posedge clk) disable iff (!rst_n_i)
        clean_i |-> victim_dirty_o);

endmodule

`default_nettype wire

//--- verilog/dcache_ctrl.sv
// data cache request controller
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl import cache_pkg::*, bus_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst_n_i,
    input  wire logic          read_valid_i,
    input  wire logic          write_valid_i,
    input  wire addr_t         addr_i,
    input  wire word_t         wdata_i,
    input  wire strb_t         strb_i,
    output word_t              rdata_o,
    output logic               ready_o,
    output mem_req_e           mem_req_o,
    output addr_t              mem_addr_o,
    output word_t              mem_wdata_o,
    input  wire word_t         mem_rdata_i,
    input  wire logic          mem_ready_i,
    output index_t             index_o,
    output tag_t               tag_o,
    output logic               tag_we_o,
    output logic               data_we_o,
    output way_t               way_o,
    output strb_t              strb_o,
    output word_t              wdata_o,
    input  wire tag_t  [1:0]   rd_tag_i,
    input  wire logic  [1:0]   rd_valid_i,
    input  wire word_t [1:0]   rd_word_i,
    input  wire way_t          victim_way_i,
    input  wire logic          victim_dirty_i,
    output logic               hit_o,
    output way_t               hit_way_o,
    output logic               write_hit_o,
    output logic               clean_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    // latched request
    logic        req_write_q;
    tag_t        req_tag_q;
    index_t      req_index_q;
    word_t       req_wdata_q;
    strb_t       req_strb_q;

    way_t        hit_way_q;
    way_t        victim_q;
    addr_t       mem_addr_q;
    word_t       mem_wdata_q;

    logic        accept;
    logic [1:0]  way_match;
    logic        lookup_hit;
    way_t        lookup_way;
    logic        refill_done;

    assign accept = (state_q == S_IDLE) && (read_valid_i || write_valid_i);

    assign way_match[0] = rd_valid_i[0] && (rd_tag_i[0] == req_tag_q);
    assign way_match[1] = rd_valid_i[1] && (rd_tag_i[1] == req_tag_q);
    assign lookup_hit   = |way_match;
    assign lookup_way   = way_t'(way_match[1]);

    assign refill_done  = (state_q == S_REFILL) && mem_ready_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            S_IDLE: begin
                if (accept) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (lookup_hit) begin
                    state_d = S_HIT;
                end else if (victim_dirty_i) begin
                    state_d = S_WRITEBACK;
                end else begin
                    state_d = S_REFILL;
                end
            end
            S_HIT: begin
                state_d = S_IDLE;
            end
            // back through lookup, the victim is clean by then
            S_WRITEBACK, S_REFILL: begin
                if (mem_ready_i) begin
                    state_d = S_LOOKUP;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            // read wins when both are raised
            req_write_q <= !read_valid_i;
            req_tag_q   <= addr_i[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
            req_index_q <= addr_i[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
            req_wdata_q <= wdata_i;
            req_strb_q  <= strb_i;
        end
        if (state_q == S_LOOKUP) begin
            hit_way_q   <= lookup_way;
            victim_q    <= victim_way_i;
            mem_wdata_q <= rd_word_i[victim_way_i];
            if (victim_dirty_i) begin
                mem_addr_q <= {rd_tag_i[victim_way_i], req_index_q,
                               {`DCACHE_OFFSET_W{1'b0}}};
            end else begin
                mem_addr_q <= {req_tag_q, req_index_q, {`DCACHE_OFFSET_W{1'b0}}};
            end
        end
    end

    // stores read at the incoming index while idle
    assign index_o = (state_q == S_IDLE) ? addr_i[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W]
                                         : req_index_q;
    assign tag_o     = req_tag_q;
    assign tag_we_o  = refill_done;
    assign data_we_o = refill_done || ((state_q == S_HIT) && req_write_q);
    assign way_o     = (state_q == S_REFILL) ? victim_q : hit_way_q;
    assign strb_o    = (state_q == S_REFILL) ? '1 : req_strb_q;
    assign wdata_o   = (state_q == S_REFILL) ? mem_rdata_i : req_wdata_q;

    assign ready_o     = (state_q == S_HIT);
    assign rdata_o     = rd_word_i[hit_way_q];
    assign hit_o       = (state_q == S_HIT);
    assign hit_way_o   = hit_way_q;
    assign write_hit_o = (state_q == S_HIT) && req_write_q;
    assign clean_o     = (state_q == S_WRITEBACK) && mem_ready_i;

    always_comb begin
        unique case (state_q)
            S_WRITEBACK: mem_req_o = MEM_WRITEBACK;
            S_REFILL:    mem_req_o = MEM_REFILL;
            default:     mem_req_o = MEM_NONE;
        endcase
    end

    assign mem_addr_o  = mem_addr_q;
    assign mem_wdata_o = mem_wdata_q;

    // ready only for a resident line that holds the request
    assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_o |-> rd_valid_i[hit_way_q] && (rd_tag_i[hit_way_q] == req_tag_q));

    // memory request held until the memory answers
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_req_o != MEM_NONE) && !mem_ready_i |=>
            (mem_req_o == $past(mem_req_o)) && $stable(mem_addr_o) && $stable(mem_wdata_o));

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
// data cache top level
`timescale 1ns/1ns
`default_nettype none

module dcache_top import cache_pkg::*, bus_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n_i,
    input  wire logic     read_valid_i,
    input  wire logic     write_valid_i,
    input  wire addr_t    addr_i,
    input  wire word_t    wdata_i,
    input  wire strb_t    strb_i,
    output word_t         rdata_o,
    output logic          ready_o,
    output mem_req_e      mem_req_o,
    output addr_t         mem_addr_o,
    output word_t         mem_wdata_o,
    input  wire word_t    mem_rdata_i,
    input  wire logic     mem_ready_i
);

    index_t       index;
    tag_t         tag;
    logic         tag_we;
    logic         data_we;
    way_t         way;
    strb_t        strb;
    word_t        wdata;
    tag_t  [1:0]  rd_tag;
    logic  [1:0]  rd_valid;
    word_t [1:0]  rd_word;
    way_t         victim_way;
    logic         victim_dirty;
    logic         hit;
    way_t         hit_way;
    logic         write_hit;
    logic         clean;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .read_valid_i   (read_valid_i),
        .write_valid_i  (write_valid_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .strb_i         (strb_i),
        .rdata_o        (rdata_o),
        .ready_o        (ready_o),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_rdata_i    (mem_rdata_i),
        .mem_ready_i    (mem_ready_i),
        .index_o        (index),
        .tag_o          (tag),
        .tag_we_o       (tag_we),
        .data_we_o      (data_we),
        .way_o          (way),
        .strb_o         (strb),
        .wdata_o        (wdata),
        .rd_tag_i       (rd_tag),
        .rd_valid_i     (rd_valid),
        .rd_word_i      (rd_word),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .write_hit_o    (write_hit),
        .clean_o        (clean)
    );

    dcache_tag_store u_tag_store (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .index_i    (index),
        .tag_we_i   (tag_we),
        .way_i      (way),
        .tag_i      (tag),
        .rd_tag_o   (rd_tag),
        .rd_valid_o (rd_valid)
    );

    dcache_data_store u_data_store (
        .clk       (clk),
        .we_i      (data_we),
        .index_i   (index),
        .way_i     (way),
        .strb_i    (strb),
        .wdata_i   (wdata),
        .rd_word_o (rd_word)
    );

    dcache_replace u_replace (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .index_i        (index),
        .valid_i        (rd_valid),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .write_hit_i    (write_hit),
        .clean_i        (clean),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

endmodule

`default_nettype wire

//--- verif/tb_mem.sv
// backing memory model
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module tb_mem import bus_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n_i,
    input  wire mem_req_e mem_req_i,
    input  wire addr_t    mem_addr_i,
    input  wire word_t    mem_wdata_i,
    output word_t         mem_rdata_o,
    output logic          mem_ready_o
);

    localparam int MAX_DELAY = 5;

    // only written words are stored
    word_t store [logic [`DCACHE_ADDR_W-`DCACHE_OFFSET_W-1:0]];
    logic  busy;
    int    wait_left;

    // contents of a word never written back
    function automatic word_t fill_word(input addr_t a);
        return {a ^ 32'hc3a5_5a3c, {a[15:0], a[31:16]} + 32'h0f1e_2d3b};
    endfunction

    function automatic word_t read_word(input addr_t a);
        if (store.exists(a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W])) begin
            return store[a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W]];
        end
        return fill_word(a);
    endfunction

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy        <= 1'b0;
            wait_left   <= 0;
            mem_ready_o <= 1'b0;
            mem_rdata_o <= '0;
        end else if (mem_ready_o) begin
            // one-cycle pulse, request goes back to NONE next
            busy        <= 1'b0;
            mem_ready_o <= 1'b0;
        end else if (mem_req_i != MEM_NONE) begin
            if (!busy) begin
                busy      <= 1'b1;
                wait_left <= int'($urandom_range(MAX_DELAY, 0));
            end else if (wait_left > 0) begin
                wait_left <= wait_left - 1;
            end else begin
                mem_ready_o <= 1'b1;
                if (mem_req_i == MEM_WRITEBACK) begin
                    store[mem_addr_i[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W]] = mem_wdata_i;
                end else begin
                    mem_rdata_o <= read_word(mem_addr_i);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_dcache.sv
// data cache testbench
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defs.svh"

module tb_dcache import bus_pkg::*; ();

    localparam int NUM_ACCESSES  = 800;
    localparam int READY_TIMEOUT = 300;
    // counted from the first cycle the request is seen
    localparam int HIT_LATENCY   = 3;

    logic     clk;
    logic     rst_n;
    logic     read_valid;
    logic     write_valid;
    addr_t    addr;
    word_t    wdata;
    strb_t    strb;
    word_t    rdata;
    logic     ready;
    mem_req_e mem_req;
    addr_t    mem_addr;
    word_t    mem_wdata;
    word_t    mem_rdata;
    logic     mem_ready;

    // reference model, flat memory plus cache state
    word_t                      model_mem [logic [`DCACHE_ADDR_W-`DCACHE_OFFSET_W-1:0]];
    logic [`DCACHE_TAG_W-1:0]   m_tag   [2][`DCACHE_SETS];
    bit                         m_valid [2][`DCACHE_SETS];
    bit                         m_dirty [2][`DCACHE_SETS];
    int                         m_age   [2][`DCACHE_SETS];

    logic [`DCACHE_TAG_W-1:0]   tag_pool [4];
    logic [`DCACHE_INDEX_W-1:0] set_pool [3];

    int errors;
    int checks;
    int accesses;
    int hits;
    int writebacks;
    int refills;
    bit timed_out;

    dcache_top dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .read_valid_i  (read_valid),
        .write_valid_i (write_valid),
        .addr_i        (addr),
        .wdata_i       (wdata),
        .strb_i        (strb),
        .rdata_o       (rdata),
        .ready_o       (ready),
        .mem_req_o     (mem_req),
        .mem_addr_o    (mem_addr),
        .mem_wdata_o   (mem_wdata),
        .mem_rdata_i   (mem_rdata),
        .mem_ready_i   (mem_ready)
    );

    tb_mem mem_model (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .mem_req_i   (mem_req),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_rdata_o (mem_rdata),
        .mem_ready_o (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    // same unwritten pattern as the backing memory
    function automatic word_t fill_word(input addr_t a);
        return {a ^ 32'hc3a5_5a3c, {a[15:0], a[31:16]} + 32'h0f1e_2d3b};
    endfunction

    function automatic word_t model_read(input addr_t a);
        if (model_mem.exists(a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W])) begin
            return model_mem[a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W]];
        end
        return fill_word({a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}});
    endfunction

    function automatic void model_write(input addr_t a, input word_t d, input strb_t s);
        word_t w;
        w = model_read(a);
        for (int b = 0; b < `DCACHE_STRB_W; b++) begin
            if (s[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        model_mem[a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W]] = w;
    endfunction

    function automatic addr_t line_addr(input logic [`DCACHE_TAG_W-1:0] t,
                                        input logic [`DCACHE_INDEX_W-1:0] s);
        return {t, s, {`DCACHE_OFFSET_W{1'b0}}};
    endfunction

    // invalid way first, then the older way, tie to way 0
    function automatic int choose_victim(input logic [`DCACHE_INDEX_W-1:0] s);
        if (!m_valid[0][s]) begin
            return 0;
        end else if (!m_valid[1][s]) begin
            return 1;
        end else if (m_age[1][s] > m_age[0][s]) begin
            return 1;
        end
        return 0;
    endfunction

    function automatic addr_t random_addr();
        int t;
        int s;
        t = int'($urandom_range(3, 0));
        s = int'($urandom_range(2, 0));
        return {tag_pool[t], set_pool[s], 3'($urandom_range(7, 0))};
    endfunction

    task automatic access(input bit is_write, input addr_t req_addr,
                          input word_t req_data, input strb_t req_strb);
        logic [`DCACHE_INDEX_W-1:0] set;
        logic [`DCACHE_TAG_W-1:0]   tag;
        int       way;
        bit       hit;
        int       exp_n;
        mem_req_e exp_kind [2];
        addr_t    exp_addr [2];
        word_t    exp_data [2];
        word_t    exp_rdata;
        int       got_n;
        mem_req_e got_kind [4];
        addr_t    got_addr [4];
        word_t    got_data [4];
        int       cycles;
        bit       done;

        set   = req_addr[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        tag   = req_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
        hit   = 1'b0;
        way   = 0;
        exp_n = 0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][set] && (m_tag[w][set] == tag)) begin
                hit = 1'b1;
                way = w;
            end
        end

        if (hit) begin
            hits++;
        end else begin
            way = choose_victim(set);
            if (m_dirty[way][set]) begin
                exp_kind[0] = MEM_WRITEBACK;
                exp_addr[0] = line_addr(m_tag[way][set], set);
                exp_data[0] = model_read(exp_addr[0]);
                exp_n = 1;
                m_dirty[way][set] = 1'b0;
                writebacks++;
            end
            exp_kind[exp_n] = MEM_REFILL;
            exp_addr[exp_n] = line_addr(tag, set);
            exp_data[exp_n] = model_read(exp_addr[exp_n]);
            exp_n++;
            m_tag[way][set]   = tag;
            m_valid[way][set] = 1'b1;
            refills++;
        end

        // every access ends as a hit on its way
        m_age[way][set] = 0;
        if (m_age[1-way][set] < `DCACHE_AGE_MAX) begin
            m_age[1-way][set]++;
        end
        if (is_write) begin
            m_dirty[way][set] = 1'b1;
            model_write(req_addr, req_data, req_strb);
        end
        exp_rdata = model_read(req_addr);

        @(posedge clk);
        read_valid  <= !is_write;
        write_valid <= is_write;
        addr        <= req_addr;
        wdata       <= req_data;
        strb        <= req_strb;

        cycles = 0;
        done   = 1'b0;
        got_n  = 0;
        while (!done && (cycles < READY_TIMEOUT)) begin
            @(negedge clk);
            cycles++;
            if (mem_ready && (mem_req != MEM_NONE) && (got_n < 4)) begin
                got_kind[got_n] = mem_req;
                got_addr[got_n] = mem_addr;
                got_data[got_n] = (mem_req == MEM_WRITEBACK) ? mem_wdata : mem_rdata;
                got_n++;
            end
            if (ready) begin
                done = 1'b1;
            end
        end

        if (done) begin
            if (!is_write) begin
                check_value("rdata_o", rdata, exp_rdata);
            end
            if (hit) begin
                check_value("ready_o latency", 64'(cycles), 64'(HIT_LATENCY));
            end
            check_value("memory request count", 64'(got_n), 64'(exp_n));
            for (int k = 0; (k < exp_n) && (k < got_n); k++) begin
                check_value("mem_req_o", 64'(got_kind[k]), 64'(exp_kind[k]));
                check_value("mem_addr_o", 64'(got_addr[k]), 64'(exp_addr[k]));
                if (exp_kind[k] == MEM_WRITEBACK) begin
                    check_value("mem_wdata_o", got_data[k], exp_data[k]);
                end else begin
                    check_value("mem_rdata_i", got_data[k], exp_data[k]);
                end
            end
            @(posedge clk);
            read_valid  <= 1'b0;
            write_valid <= 1'b0;
            accesses++;
        end else begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: ready_o never came for the access to address %h", req_addr);
        end
    endtask

    initial begin
        addr_t next_addr;
        word_t next_data;
        strb_t next_strb;
        bit    is_write;
        int    idle;

        void'($urandom(35614));
        rst_n       = 1'b0;
        read_valid  = 1'b0;
        write_valid = 1'b0;
        addr        = '0;
        wdata       = '0;
        strb        = '0;
        errors      = 0;
        checks      = 0;
        accesses    = 0;
        hits        = 0;
        writebacks  = 0;
        refills     = 0;
        timed_out   = 1'b0;

        // four tags on three sets, so two ways overflow often
        for (int k = 0; k < 4; k++) begin
            tag_pool[k] = {20'($urandom), 3'(k)};
        end
        set_pool[0] = 6'd0;
        set_pool[1] = 6'd21;
        set_pool[2] = 6'd63;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("ready_o", 64'(ready), 64'd0);
        check_value("mem_req_o", 64'(mem_req), 64'(MEM_NONE));

        next_addr = random_addr();
        for (int i = 0; (i < NUM_ACCESSES) && !timed_out; i++) begin
            is_write  = ($urandom_range(1, 0) == 1);
            next_data = {$urandom, $urandom};
            // a write always carries at least one byte
            next_strb = strb_t'($urandom_range(255, 1));
            access(is_write, next_addr, next_data, next_strb);
            // keep the address now and then so repeat hits follow
            if ($urandom_range(3, 0) != 0) begin
                next_addr = random_addr();
            end
            idle = int'($urandom_range(2, 0));
            repeat (idle) @(posedge clk);
        end
        $display("accesses %0d, hits %0d, writebacks %0d, refills %0d, checks %0d, errors %0d",
                 accesses, hits, writebacks, refills, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/bus_pkg.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_replace.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verif/tb_mem.sv
verif/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ns \
    --top-module tb_dcache \
    -f dcache.f

./obj_dir/Vtb_dcache | tee sim.log

grep -q "All tests passed" sim.log
